// ==== include/writeback_defines.svh ====
/*
 * Width macros for the writeback stage packet fields.
 * Flag bit positions inside the execution flag field.
 */

`ifndef WRITEBACK_DEFINES_SVH
`define WRITEBACK_DEFINES_SVH

////////////////////////////////////////
// Field widths.
////////////////////////////////////////
`define SIZE_PC                 32      // Instruction address.
`define SIZE_DATA               32      // Result data.
`define SIZE_PHYSICAL_LOG       7       // Physical register tag.
`define SIZE_ACTIVELIST_LOG     7       // Active list index.
`define SIZE_ISSUEQ_LOG         5       // Issue queue entry.
`define SIZE_LSQ_LOG            5       // Load-store queue id.
`define CHECKPOINTS_LOG         2       // Branch tag id.
`define SIZE_CTI_LOG            4       // Control-transfer queue index.
`define EXECUTION_FLAGS         6
`define WRITEBACK_FLAGS         4       // Low flag bits sent to the active list.

////////////////////////////////////////
// Flag bit positions.
////////////////////////////////////////
`define FLAG_BYPASS             4       // Result writes a register.
`define FLAG_CONDITIONAL        5       // Conditional branch.

`endif

// ==== source/wbPacketPkg.sv ====
/*
 * Packet types arriving at writeback.
 * Execute unit result packet and load-store unit result packet.
 */

`default_nettype none

`include "writeback_defines.svh"

package wbPacketPkg;

        // Result packet from an integer execute unit.
        typedef struct packed {
                logic [`EXECUTION_FLAGS-1:0]     flags;
                logic [`SIZE_PHYSICAL_LOG-1:0]   physDest;
                logic [`SIZE_ACTIVELIST_LOG-1:0] alId;
                logic [`SIZE_DATA-1:0]           data;
                logic [`SIZE_ISSUEQ_LOG-1:0]     iqEntry;
                logic [`SIZE_LSQ_LOG-1:0]        lsqId;
                logic [`CHECKPOINTS_LOG-1:0]     smtId;     // Branch tag.
                logic [`SIZE_CTI_LOG-1:0]        ctiIndex;
                logic [`SIZE_PC-1:0]             targetAddr;
                logic                            brDirection;
        } exePacket_t;

        // Result packet from the load-store unit.
        typedef struct packed {
                logic [`EXECUTION_FLAGS-1:0]     flags;
                logic [`SIZE_DATA-1:0]           data;
                logic [`SIZE_PHYSICAL_LOG-1:0]   physDest;
                logic [`SIZE_ACTIVELIST_LOG-1:0] alId;
                logic [`SIZE_ISSUEQ_LOG-1:0]     iqEntry;   // Agen entry to free.
        } lsuPacket_t;

endpackage

`default_nettype wire

// ==== source/wbResultPkg.sv ====
/*
 * Result types leaving writeback.
 * Active list control word, bypass packet, load-violation report.
 */

`default_nettype none

`include "writeback_defines.svh"

package wbResultPkg;

        typedef struct packed {
                logic [`SIZE_ACTIVELIST_LOG-1:0] alId;
                logic [`WRITEBACK_FLAGS-1:0]     wbFlags;
        } wbCtrl_t;

        // Forwarded to issue queue and register read.
        typedef struct packed {
                logic [`SIZE_PHYSICAL_LOG-1:0]   physDest;
                logic [`SIZE_DATA-1:0]           data;
                logic [`CHECKPOINTS_LOG-1:0]     smtId;
        } bypassPacket_t;

        typedef struct packed {
                logic                            violation;
                logic [`SIZE_ACTIVELIST_LOG-1:0] alId;  // Offending load.
        } ldViolation_t;

endpackage

`default_nettype wire

// ==== source/exeLaneLatch.sv ====
/*
 * One execute lane of writeback.
 * Registers the result packet and forms the writeback word and bypass packet.
 */

`timescale 1ns/10ps
`default_nettype none

`include "writeback_defines.svh"

module exeLaneLatch (
        input  logic                       clk,
        input  logic                       reset,
        input  logic                       valid_i,
        input  wbPacketPkg::exePacket_t    packet_i,
        output logic                       writebkValid_o,
        output wbResultPkg::wbCtrl_t       ctrlFu_o,
        output logic                       bypassValid_o,
        output wbResultPkg::bypassPacket_t bypassPacket_o,
        output wbPacketPkg::exePacket_t    lanePacket_o
);

logic                    laneValid;
wbPacketPkg::exePacket_t lanePacket;

////////////////////////////////////////
// Lane registers.
////////////////////////////////////////
always_ff @(posedge clk)
begin
        if (reset)
        begin
                laneValid  <= 1'b0;
                lanePacket <= '0;
        end
        else
        begin
                laneValid <= valid_i;
                if (valid_i)
                begin
                        lanePacket <= packet_i;     // Hold otherwise.
                end
        end
end

////////////////////////////////////////
// Outputs.
////////////////////////////////////////
assign writebkValid_o   = laneValid;
assign ctrlFu_o.alId    = lanePacket.alId;
assign ctrlFu_o.wbFlags = lanePacket.flags[`WRITEBACK_FLAGS-1:0];

assign bypassValid_o           = laneValid & lanePacket.flags[`FLAG_BYPASS];
assign bypassPacket_o.physDest = lanePacket.physDest;
assign bypassPacket_o.data     = lanePacket.data;
assign bypassPacket_o.smtId    = lanePacket.smtId;

assign lanePacket_o = lanePacket;   // Used for branch resolution.

// A bypass follows the flag of the packet accepted one cycle before.
bypassFromFlag: assert property (@(posedge clk) disable iff (reset)
        valid_i |=> writebkValid_o && bypassValid_o == $past(packet_i.flags[`FLAG_BYPASS]));

// Nothing writes back in the cycle after reset.
noWritebackAfterReset: assert property (@(posedge clk) reset |=> !writebkValid_o);

endmodule

`default_nettype wire

// ==== source/lsuLaneLatch.sv ====
/*
 * Load-store lane of writeback.
 * Registers the load-store result with its load-violation report.
 * Forms writeback, bypass and agen issue queue free outputs.
 */

`timescale 1ns/10ps
`default_nettype none

`include "writeback_defines.svh"

module lsuLaneLatch (
        input  logic                            clk,
        input  logic                            reset,
        input  logic                            valid_i,
        input  wbPacketPkg::lsuPacket_t         packet_i,
        input  wbResultPkg::ldViolation_t       ldViolation_i,
        output logic                            writebkValid_o,
        output wbResultPkg::wbCtrl_t            ctrlFu_o,
        output logic                            bypassValid_o,
        output logic [`SIZE_PHYSICAL_LOG-1:0]   bypassDest_o,
        output logic [`SIZE_DATA-1:0]           bypassData_o,
        output logic                            agenIqFreedValid_o,
        output logic [`SIZE_ISSUEQ_LOG-1:0]     agenIqEntry_o,
        output wbResultPkg::ldViolation_t       ldViolation_o
);

logic                      laneValid;
wbPacketPkg::lsuPacket_t   lanePacket;
wbResultPkg::ldViolation_t ldViolation;

////////////////////////////////////////
// Lane registers.
////////////////////////////////////////
always_ff @(posedge clk)
begin
        if (reset)
        begin
                laneValid   <= 1'b0;
                lanePacket  <= '0;
                ldViolation <= '0;
        end
        else
        begin
                laneValid <= valid_i;
                // Report is captured together with its load.
                if (valid_i)
                begin
                        lanePacket  <= packet_i;
                        ldViolation <= ldViolation_i;
                end
        end
end

////////////////////////////////////////
// Outputs.
////////////////////////////////////////
assign writebkValid_o   = laneValid;
assign ctrlFu_o.alId    = lanePacket.alId;
assign ctrlFu_o.wbFlags = lanePacket.flags[`WRITEBACK_FLAGS-1:0];

assign bypassValid_o = laneValid & lanePacket.flags[`FLAG_BYPASS];
assign bypassDest_o  = lanePacket.physDest;
assign bypassData_o  = lanePacket.data;

// Agen entry is released as the load writes back.
assign agenIqFreedValid_o = laneValid;
assign agenIqEntry_o      = lanePacket.iqEntry;

assign ldViolation_o = ldViolation;

// The entry freed is the one of the load accepted a cycle before.
agenFreeAfterLoad: assert property (@(posedge clk) disable iff (reset)
        valid_i |=> agenIqFreedValid_o && agenIqEntry_o == $past(packet_i.iqEntry));

// Report holds through cycles without a load.
ldViolationHeld: assert property (@(posedge clk) disable iff (reset)
        !valid_i |=> $stable(ldViolation_o));

endmodule

`default_nettype wire

// ==== source/writeBack.sv ====
/*
 * Writeback stage top.
 * Three execute lanes, one load-store lane, branch resolution from lane 2.
 */

`timescale 1ns/10ps
`default_nettype none

`include "writeback_defines.svh"

module writeBack (
        input  logic                            clk,
        input  logic                            reset,

        input  logic                            exePacketValid0_i,
        input  wbPacketPkg::exePacket_t         exePacket0_i,
        input  logic                            exePacketValid1_i,
        input  wbPacketPkg::exePacket_t         exePacket1_i,
        input  logic                            exePacketValid2_i,
        input  wbPacketPkg::exePacket_t         exePacket2_i,

        input  logic                            lsuPacketValid_i,
        input  wbPacketPkg::lsuPacket_t         lsuPacket_i,
        input  wbResultPkg::ldViolation_t       ldViolationPacket_i,

        output logic                            writebkValid0_o,
        output wbResultPkg::wbCtrl_t            ctrlFu0_o,
        output logic                            bypassValid0_o,
        output wbResultPkg::bypassPacket_t      bypassPacket0_o,
        output logic                            writebkValid1_o,
        output wbResultPkg::wbCtrl_t            ctrlFu1_o,
        output logic                            bypassValid1_o,
        output wbResultPkg::bypassPacket_t      bypassPacket1_o,
        output logic                            writebkValid2_o,
        output wbResultPkg::wbCtrl_t            ctrlFu2_o,
        output logic                            bypassValid2_o,
        output wbResultPkg::bypassPacket_t      bypassPacket2_o,
        output logic                            writebkValid3_o,
        output wbResultPkg::wbCtrl_t            ctrlFu3_o,
        output logic                            bypassValid3_o,
        output wbResultPkg::bypassPacket_t      bypassPacket3_o,

        output logic                            agenIqFreedValid_o,
        output logic [`SIZE_ISSUEQ_LOG-1:0]     agenIqEntry_o,
        output wbResultPkg::ldViolation_t       ldViolationPacket_o,

        output logic                            ctrlVerified_o,
        output logic                            ctrlConditional_o,
        output logic                            ctrlBrDirection_o,
        output logic [`CHECKPOINTS_LOG-1:0]     ctrlSmtId_o,
        output logic [`SIZE_PC-1:0]             ctrlTargetAddr_o,
        output logic [`SIZE_CTI_LOG-1:0]        ctrlCtiQueueIndex_o
);

wbPacketPkg::exePacket_t        branchPacket;   // Registered lane 2 packet.
logic [`SIZE_PHYSICAL_LOG-1:0]  lsuBypassDest;
logic [`SIZE_DATA-1:0]          lsuBypassData;

////////////////////////////////////////
// Execute lanes.
////////////////////////////////////////
exeLaneLatch exeLane0 (
        .clk            (clk),
        .reset          (reset),
        .valid_i        (exePacketValid0_i),
        .packet_i       (exePacket0_i),
        .writebkValid_o (writebkValid0_o),
        .ctrlFu_o       (ctrlFu0_o),
        .bypassValid_o  (bypassValid0_o),
        .bypassPacket_o (bypassPacket0_o),
        .lanePacket_o   ()
);

exeLaneLatch exeLane1 (
        .clk            (clk),
        .reset          (reset),
        .valid_i        (exePacketValid1_i),
        .packet_i       (exePacket1_i),
        .writebkValid_o (writebkValid1_o),
        .ctrlFu_o       (ctrlFu1_o),
        .bypassValid_o  (bypassValid1_o),
        .bypassPacket_o (bypassPacket1_o),
        .lanePacket_o   ()
);

exeLaneLatch exeLane2 (
        .clk            (clk),
        .reset          (reset),
        .valid_i        (exePacketValid2_i),
        .packet_i       (exePacket2_i),
        .writebkValid_o (writebkValid2_o),
        .ctrlFu_o       (ctrlFu2_o),
        .bypassValid_o  (bypassValid2_o),
        .bypassPacket_o (bypassPacket2_o),
        .lanePacket_o   (branchPacket)
);

////////////////////////////////////////
// Load-store lane.
////////////////////////////////////////
lsuLaneLatch lsuLane (
        .clk                (clk),
        .reset              (reset),
        .valid_i            (lsuPacketValid_i),
        .packet_i           (lsuPacket_i),
        .ldViolation_i      (ldViolationPacket_i),
        .writebkValid_o     (writebkValid3_o),
        .ctrlFu_o           (ctrlFu3_o),
        .bypassValid_o      (bypassValid3_o),
        .bypassDest_o       (lsuBypassDest),
        .bypassData_o       (lsuBypassData),
        .agenIqFreedValid_o (agenIqFreedValid_o),
        .agenIqEntry_o      (agenIqEntry_o),
        .ldViolation_o      (ldViolationPacket_o)
);

// Loads carry no branch tag.
assign bypassPacket3_o.physDest = lsuBypassDest;
assign bypassPacket3_o.data     = lsuBypassData;
assign bypassPacket3_o.smtId    = '0;

////////////////////////////////////////
// Branch resolution.
////////////////////////////////////////
assign ctrlVerified_o      = writebkValid2_o;
assign ctrlConditional_o   = branchPacket.flags[`FLAG_CONDITIONAL];
assign ctrlBrDirection_o   = branchPacket.brDirection;
assign ctrlSmtId_o         = branchPacket.smtId;
assign ctrlTargetAddr_o    = branchPacket.targetAddr;
assign ctrlCtiQueueIndex_o = branchPacket.ctiIndex;

endmodule

`default_nettype wire

// ==== tests/writeBackTb.sv ====
/*
 * Testbench for the writeback stage.
 * Clock, reset, random lane stimulus, lane model, check task,
 * watchdog and closing report.
 */

`timescale 1ns/10ps
`default_nettype none

`include "writeback_defines.svh"

module writeBackTb;

localparam int RESET_CYCLES = 2;
localparam int EXE_CYCLES   = 200;
localparam int LSU_CYCLES   = 200;
localparam int MIX_CYCLES   = 200;
localparam int ALL_CYCLES   = 100;
localparam int TOTAL_CYCLES = RESET_CYCLES + EXE_CYCLES + LSU_CYCLES + MIX_CYCLES + ALL_CYCLES + 4;
localparam int TIMEOUT_NS   = TOTAL_CYCLES * 10 + 200;

logic clk;
logic reset;
integer seed;
int errorCount;
int checkCount;

logic                       exeValidIn [3];
wbPacketPkg::exePacket_t    exeIn [3];
logic                       lsuValidIn;
wbPacketPkg::lsuPacket_t    lsuIn;
wbResultPkg::ldViolation_t  ldViolationIn;

logic                       wbValidOut [4];
wbResultPkg::wbCtrl_t       ctrlOut [4];
logic                       bypassValidOut [4];
wbResultPkg::bypassPacket_t bypassOut [4];
logic                       agenValidOut;
logic [`SIZE_ISSUEQ_LOG-1:0] agenEntryOut;
wbResultPkg::ldViolation_t  ldViolationOut;
logic                       verifiedOut;
logic                       conditionalOut;
logic                       brDirectionOut;
logic [`CHECKPOINTS_LOG-1:0] smtIdOut;
logic [`SIZE_PC-1:0]        targetOut;
logic [`SIZE_CTI_LOG-1:0]   ctiIndexOut;

// Model copy of each lane register.
logic                       modelExeValid [3];
wbPacketPkg::exePacket_t    modelExe [3];
logic                       modelLsuValid;
wbPacketPkg::lsuPacket_t    modelLsu;
wbResultPkg::ldViolation_t  modelLdViolation;

writeBack dut (
        .clk                 (clk),
        .reset               (reset),
        .exePacketValid0_i   (exeValidIn[0]),
        .exePacket0_i        (exeIn[0]),
        .exePacketValid1_i   (exeValidIn[1]),
        .exePacket1_i        (exeIn[1]),
        .exePacketValid2_i   (exeValidIn[2]),
        .exePacket2_i        (exeIn[2]),
        .lsuPacketValid_i    (lsuValidIn),
        .lsuPacket_i         (lsuIn),
        .ldViolationPacket_i (ldViolationIn),
        .writebkValid0_o     (wbValidOut[0]),
        .ctrlFu0_o           (ctrlOut[0]),
        .bypassValid0_o      (bypassValidOut[0]),
        .bypassPacket0_o     (bypassOut[0]),
        .writebkValid1_o     (wbValidOut[1]),
        .ctrlFu1_o           (ctrlOut[1]),
        .bypassValid1_o      (bypassValidOut[1]),
        .bypassPacket1_o     (bypassOut[1]),
        .writebkValid2_o     (wbValidOut[2]),
        .ctrlFu2_o           (ctrlOut[2]),
        .bypassValid2_o      (bypassValidOut[2]),
        .bypassPacket2_o     (bypassOut[2]),
        .writebkValid3_o     (wbValidOut[3]),
        .ctrlFu3_o           (ctrlOut[3]),
        .bypassValid3_o      (bypassValidOut[3]),
        .bypassPacket3_o     (bypassOut[3]),
        .agenIqFreedValid_o  (agenValidOut),
        .agenIqEntry_o       (agenEntryOut),
        .ldViolationPacket_o (ldViolationOut),
        .ctrlVerified_o      (verifiedOut),
        .ctrlConditional_o   (conditionalOut),
        .ctrlBrDirection_o   (brDirectionOut),
        .ctrlSmtId_o         (smtIdOut),
        .ctrlTargetAddr_o    (targetOut),
        .ctrlCtiQueueIndex_o (ctiIndexOut)
);

initial
begin
        clk = 1'b0;
        forever #5 clk = ~clk;
end

////////////////////////////////////////
// Lane model.
////////////////////////////////////////
always @(posedge clk)
begin
        for (int n = 0; n < 3; n++)
        begin
                if (reset)
                begin
                        modelExeValid[n] <= 1'b0;
                        modelExe[n]      <= '0;
                end
                else
                begin
                        modelExeValid[n] <= exeValidIn[n];
                        if (exeValidIn[n])
                        begin
                                modelExe[n] <= exeIn[n];
                        end
                end
        end
        if (reset)
        begin
                modelLsuValid    <= 1'b0;
                modelLsu         <= '0;
                modelLdViolation <= '0;
        end
        else
        begin
                modelLsuValid <= lsuValidIn;
                if (lsuValidIn)
                begin
                        modelLsu         <= lsuIn;      // Report travels with its load.
                        modelLdViolation <= ldViolationIn;
                end
        end
end

task compareValue(input logic [63:0] actual, input logic [63:0] expected, input string what);
        checkCount++;
        if (actual !== expected)
        begin
                errorCount++;
                $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
endtask

task checkOutputs();
        int n;
        for (n = 0; n < 3; n++)
        begin
                compareValue(64'(wbValidOut[n]), 64'(modelExeValid[n]),
                             $sformatf("writebkValid%0d_o", n));
                compareValue(64'(ctrlOut[n]),
                             64'({modelExe[n].alId, modelExe[n].flags[`WRITEBACK_FLAGS-1:0]}),
                             $sformatf("ctrlFu%0d_o", n));
                compareValue(64'(bypassValidOut[n]),
                             64'(modelExeValid[n] & modelExe[n].flags[`FLAG_BYPASS]),
                             $sformatf("bypassValid%0d_o", n));
                compareValue(64'(bypassOut[n]),
                             64'({modelExe[n].physDest, modelExe[n].data, modelExe[n].smtId}),
                             $sformatf("bypassPacket%0d_o", n));
        end
        compareValue(64'(wbValidOut[3]), 64'(modelLsuValid), "writebkValid3_o");
        compareValue(64'(ctrlOut[3]),
                     64'({modelLsu.alId, modelLsu.flags[`WRITEBACK_FLAGS-1:0]}), "ctrlFu3_o");
        compareValue(64'(bypassValidOut[3]), 64'(modelLsuValid & modelLsu.flags[`FLAG_BYPASS]),
                     "bypassValid3_o");
        compareValue(64'(bypassOut[3]),
                     64'({modelLsu.physDest, modelLsu.data, 2'b00}), "bypassPacket3_o");
        compareValue(64'(agenValidOut), 64'(modelLsuValid), "agenIqFreedValid_o");
        compareValue(64'(agenEntryOut), 64'(modelLsu.iqEntry), "agenIqEntry_o");
        compareValue(64'(ldViolationOut), 64'(modelLdViolation), "ldViolationPacket_o");

        // Branch resolution comes from lane 2 only.
        compareValue(64'(verifiedOut), 64'(modelExeValid[2]), "ctrlVerified_o");
        compareValue(64'(conditionalOut), 64'(modelExe[2].flags[`FLAG_CONDITIONAL]),
                     "ctrlConditional_o");
        compareValue(64'(brDirectionOut), 64'(modelExe[2].brDirection), "ctrlBrDirection_o");
        compareValue(64'(smtIdOut), 64'(modelExe[2].smtId), "ctrlSmtId_o");
        compareValue(64'(targetOut), 64'(modelExe[2].targetAddr), "ctrlTargetAddr_o");
        compareValue(64'(ctiIndexOut), 64'(modelExe[2].ctiIndex), "ctrlCtiQueueIndex_o");
endtask

// Payloads change every cycle, valid or not, so held values get exercised.
task driveStimulus(input logic exeOn, input logic lsuOn, input logic forceValid);
        logic [127:0] bits;
        logic [31:0]  word;
        int n;
        for (n = 0; n < 3; n++)
        begin
                bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
                word = $random(seed);
                exeIn[n]      = bits[$bits(wbPacketPkg::exePacket_t)-1:0];
                exeValidIn[n] = exeOn & (forceValid | word[0]);
        end
        bits = {$random(seed), $random(seed), $random(seed), $random(seed)};
        word = $random(seed);
        lsuIn         = bits[56:0];
        ldViolationIn = word[15:8];
        lsuValidIn    = lsuOn & (forceValid | word[0]);
endtask

task runTest(input string name, input int cycles, input logic exeOn, input logic lsuOn,
             input logic forceValid);
        int startErrors;
        int i;
        startErrors = errorCount;
        for (i = 0; i < cycles; i++)
        begin
                @(negedge clk);
                checkOutputs();
                driveStimulus(exeOn, lsuOn, forceValid);
        end
        $display("Test %s finished: %0d cycles, %0d errors", name, cycles,
                 errorCount - startErrors);
endtask

////////////////////////////////////////
// Watchdog.
////////////////////////////////////////
initial
begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Testbench failed");
        $finish;
end

initial
begin
        seed          = 32'hf626_acc4;
        errorCount    = 0;
        checkCount    = 0;
        reset         = 1'b1;
        // Valid packets offered during reset must not register.
        driveStimulus(1'b1, 1'b1, 1'b1);
        repeat (RESET_CYCLES) @(negedge clk);

        for (int n = 0; n < 4; n++)
        begin
                compareValue(64'(wbValidOut[n]), 64'd0, $sformatf("writebkValid%0d_o", n));
                compareValue(64'(bypassValidOut[n]), 64'd0, $sformatf("bypassValid%0d_o", n));
        end
        compareValue(64'(agenValidOut), 64'd0, "agenIqFreedValid_o");
        compareValue(64'(verifiedOut), 64'd0, "ctrlVerified_o");
        compareValue(64'(ldViolationOut), 64'd0, "ldViolationPacket_o");
        checkOutputs();
        $display("Test reset finished: %0d errors", errorCount);

        reset         = 1'b0;
        lsuValidIn    = 1'b0;
        lsuIn         = '0;
        ldViolationIn = '0;
        for (int n = 0; n < 3; n++)
        begin
                exeValidIn[n] = 1'b0;
                exeIn[n]      = '0;
        end

        runTest("execute", EXE_CYCLES, 1'b1, 1'b0, 1'b0);
        runTest("lsu", LSU_CYCLES, 1'b0, 1'b1, 1'b0);
        runTest("mixed", MIX_CYCLES, 1'b1, 1'b1, 1'b0);
        runTest("concurrency", ALL_CYCLES, 1'b1, 1'b1, 1'b1);
        @(negedge clk);
        checkOutputs();

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
        begin
                $display("Testbench passed");
        end
        else
        begin
                $display("Testbench failed");
        end
        $finish;
end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+include
source/wbPacketPkg.sv
source/wbResultPkg.sv
source/exeLaneLatch.sv
source/lsuLaneLatch.sv
source/writeBack.sv
tests/writeBackTb.sv

// ==== Makefile ====
# Verilator simulation of the writeback stage.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = writeBackTb
FILELIST  = compile.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
